/* run.sh */
#!/usr/bin/env bash
# Build and run the Karatsuba multiplier testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module kmul_tb -Mdir obj_dir -o kmul_sim

# Raised error limit lets the testbench print its verdict after an assertion error
./obj_dir/kmul_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

/* src.f */
+incdir+verilog
verilog/kmul_pkg.sv
verilog/kmul_prod_rom.sv
verilog/kmul_datapath.sv
verilog/kmul_ctrl.sv
verilog/kmul_apb_regs.sv
verilog/kmul_top.sv
verif/kmul_assert.sv
verif/kmul_tb.sv

/* verif/kmul_assert.sv */
module kmul_assert import kmul_pkg::*; (
    input logic       CLK,
    input logic       RESET,
    input logic       PSEL,
    input logic       PENABLE,
    input logic       PSLVERR,
    input kmul_ctrl_t ctrl,
    input kmul_stat_t stat
);

    int trip_cnt = 0;                                       // Failed assertions so far

    // ROM address walks low, high, then sums
    rom_low_high: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.rom_sel == 2'd1 |=> ctrl.rom_sel == 2'd2)
        else begin
            $error("rom_sel 1 not followed by 2");
            trip_cnt++;
        end

    rom_high_sum: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.rom_sel == 2'd2 |=> ctrl.rom_sel == 2'd3)
        else begin
            $error("rom_sel 2 not followed by 3");
            trip_cnt++;
        end

    res_then_done: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.ld_res |=> stat.done)
        else begin
            $error("done missing after ld_res");
            trip_cnt++;
        end

    // Error response only while the transfer completes
    slverr_access: assert property (@(posedge CLK) disable iff (RESET)
        PSLVERR |-> (PSEL && PENABLE))
        else begin
            $error("PSLVERR outside the access phase");
            trip_cnt++;
        end

    busy_done_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(stat.busy && stat.done))
        else begin
            $error("busy and done high together");
            trip_cnt++;
        end

endmodule

bind kmul_top kmul_assert u_assert (
    .CLK     (CLK),
    .RESET   (RESET),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PSLVERR (PSLVERR),
    .ctrl    (ctrl),
    .stat    (stat)
);

/* verif/kmul_tb.sv */
`include "kmul_defines.svh"

module kmul_tb import kmul_pkg::*; ();

    localparam int HALF     = 5;                            // Half clock period
    localparam int N_OPS    = 74;                           // Multiplications over all tests
    localparam int APB_OVH  = 24;                           // APB cycles around one multiplication
    localparam int WD_LIMIT = 2 * N_OPS * (`KMUL_LATENCY + APB_OVH) * 2 * HALF;

    logic        CLK;
    logic        RESET;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [3:0]  PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    logic [31:0] lfsr_q;                                    // Random state
    string       cur_test;
    int          test_err;                                  // Errors in the running test
    int          n_err;
    int          n_ok;
    int          n_tests;

    kmul_top u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR)
    );

    always #HALF CLK = ~CLK;                                // 10-unit period

    // Galois LFSR with taps at 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [`KMUL_W-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);                     // One step per bit
            val    = {val[`KMUL_W-2:0], lfsr_q[0]};
        end
    endtask

    function automatic kmul_stat_t stat_of(input logic busy, input logic done, input logic ovr);
        kmul_stat_t s;
        s.busy    = busy;
        s.done    = done;
        s.overrun = ovr;
        return s;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge CLK);                                     // Setup phase
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge CLK);                                     // Access phase
        PENABLE = 1'b1;
        #(HALF - 1);                                        // Just before the closing edge
        rdata = PRDATA;
        err   = PSLVERR;
        if (!PREADY) begin
            $display("%s: PREADY was low during an access phase", cur_test);
            test_err++;
        end
        @(negedge CLK);
        PSEL    = 1'b0;                                     // Back to idle
        PENABLE = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic cmp_result(input logic [2*`KMUL_W-1:0] exp, input logic [2*`KMUL_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s result expected %h actual %h", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic cmp_stat(input kmul_stat_t exp, input kmul_stat_t act);
        if (act !== exp) begin
            $display("ERR %s stat expected %b actual %b", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic cmp_opnd(input kmul_opnd_view_t exp, input kmul_opnd_view_t act);
        if (act !== exp) begin
            $display("ERR %s opnd expected %h actual %h", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic cmp_slverr(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s pslverr expected %b actual %b", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic end_test();
        n_tests++;
        n_err += test_err;
        if (test_err == 0) begin
            n_ok++;
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_err);
        end
    endtask

    // Bounded poll of STAT until done
    task automatic wait_done();
        logic [31:0] rd;
        logic        err;
        kmul_stat_t  st;
        int          polls;
        polls = 0;
        do begin
            apb_read(`KMUL_ADDR_STAT, rd, err);
            st = kmul_stat_t'(rd[2:0]);
            polls++;
        end while (!st.done && polls < 2 * `KMUL_LATENCY);
        if (!st.done) begin
            $display("%s: done flag never came up after %0d status reads", cur_test, polls);
            test_err++;
        end
    endtask

    task automatic run_mul(input logic [`KMUL_W-1:0] x, input logic [`KMUL_W-1:0] y);
        logic [31:0] rd;
        logic        err;
        apb_write(`KMUL_ADDR_OPND, {16'h0000, x, y}, err);
        cmp_slverr(1'b0, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);             // Start
        cmp_slverr(1'b0, err);
        wait_done();
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result({8'h00, x} * {8'h00, y}, rd[15:0]);
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        err;
        begin_test("reset_state");
        apb_read(`KMUL_ADDR_STAT, rd, err);
        cmp_slverr(1'b0, err);
        cmp_stat(stat_of(1'b0, 1'b0, 1'b0), kmul_stat_t'(rd[2:0]));
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result('0, rd[15:0]);
        apb_read(4'h2, rd, err);                            // Unmapped offset
        cmp_slverr(1'b1, err);
        end_test();
    endtask

    task automatic test_corners();
        begin_test("corners");
        run_mul(8'd0, 8'd0);
        run_mul(8'd255, 8'd255);                            // Largest sums into the ROM
        run_mul(8'd15, 8'd15);
        run_mul(8'd16, 8'd16);
        run_mul(8'd240, 8'd15);                             // Only the middle term is non-zero
        end_test();
    endtask

    task automatic test_latency();
        logic [31:0] rd;
        logic        err;
        begin_test("latency");
        apb_write(`KMUL_ADDR_OPND, {16'h0000, 8'd200, 8'd123}, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);             // Returns half a cycle after start edge
        repeat (`KMUL_LATENCY - 3) @(negedge CLK);          // Next read samples between edges 6 and 7
        apb_read(`KMUL_ADDR_STAT, rd, err);
        cmp_stat(stat_of(1'b1, 1'b0, 1'b0), kmul_stat_t'(rd[2:0]));
        wait_done();
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result(16'd24600, rd[15:0]);
        apb_write(`KMUL_ADDR_OPND, {16'h0000, 8'd99, 8'd201}, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);
        repeat (`KMUL_LATENCY - 2) @(negedge CLK);          // Next read samples between edges 7 and 8
        apb_read(`KMUL_ADDR_RES, rd, err);                  // 7 clocks after the start edge
        cmp_result(16'd19899, rd[15:0]);
        apb_read(`KMUL_ADDR_STAT, rd, err);
        cmp_stat(stat_of(1'b0, 1'b1, 1'b0), kmul_stat_t'(rd[2:0]));
        end_test();
    endtask

    task automatic test_random();
        logic [`KMUL_W-1:0] x;
        logic [`KMUL_W-1:0] y;
        begin_test("random");
        for (int i = 0; i < 64; i++) begin
            take_bits(`KMUL_W, x);
            take_bits(`KMUL_W, y);
            run_mul(x, y);
        end
        end_test();
    endtask

    task automatic test_overrun();
        logic [31:0] rd;
        logic        err;
        begin_test("overrun");
        apb_write(`KMUL_ADDR_OPND, {16'h0000, 8'd173, 8'd94}, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);
        cmp_slverr(1'b0, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);             // Lands while busy
        cmp_slverr(1'b1, err);
        apb_read(`KMUL_ADDR_STAT, rd, err);
        cmp_stat(stat_of(1'b1, 1'b0, 1'b1), kmul_stat_t'(rd[2:0]));
        wait_done();
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result(16'd16262, rd[15:0]);                    // First product untouched
        apb_write(`KMUL_ADDR_CTRL, 32'h2, err);             // clear_done also drops overrun
        cmp_slverr(1'b0, err);
        apb_read(`KMUL_ADDR_STAT, rd, err);
        cmp_stat(stat_of(1'b0, 1'b0, 1'b0), kmul_stat_t'(rd[2:0]));
        end_test();
    endtask

    task automatic test_rewrite();
        logic [31:0] rd;
        logic        err;
        begin_test("rewrite");
        apb_write(`KMUL_ADDR_OPND, {16'h0000, 8'd77, 8'd201}, err);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);
        apb_write(`KMUL_ADDR_OPND, {16'h0000, 8'd9, 8'd250}, err);  // After ld_xy
        cmp_slverr(1'b0, err);
        apb_read(`KMUL_ADDR_OPND, rd, err);
        cmp_opnd(kmul_opnd_view_t'({16'h0000, 8'd9, 8'd250}), kmul_opnd_view_t'(rd));
        wait_done();
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result(16'd15477, rd[15:0]);
        apb_write(`KMUL_ADDR_CTRL, 32'h1, err);             // Picks up the new pair
        wait_done();
        apb_read(`KMUL_ADDR_RES, rd, err);
        cmp_result(16'd2250, rd[15:0]);
        end_test();
    endtask

    initial begin
        CLK      = 1'b0;
        RESET    = 1'b1;
        PSEL     = 1'b0;
        PENABLE  = 1'b0;
        PWRITE   = 1'b0;
        PADDR    = '0;
        PWDATA   = '0;
        lfsr_q   = 32'h8ba2;
        n_err    = 0;
        n_ok     = 0;
        n_tests  = 0;
        test_err = 0;
        cur_test = "init";
        repeat (2) @(negedge CLK);                          // Two rising edges in reset
        RESET = 1'b0;
        test_reset_state();
        test_corners();
        test_latency();
        test_random();
        test_overrun();
        test_rewrite();
        $display("%0d of %0d tests clean, %0d errors, %0d assertion failures",
                 n_ok, n_tests, n_err, u_dut.u_assert.trip_cnt);
        if (n_err == 0 && u_dut.u_assert.trip_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WD_LIMIT);
        $display("run timed out after %0d time units, a test is stuck", WD_LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule

/* verilog/kmul_apb_regs.sv */
`include "kmul_defines.svh"

module kmul_apb_regs import kmul_pkg::*; (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 PSEL,
    input  logic                 PENABLE,
    input  logic                 PWRITE,
    input  logic [3:0]           PADDR,
    input  logic [31:0]          PWDATA,
    output logic [31:0]          PRDATA,
    output logic                 PREADY,
    output logic                 PSLVERR,
    output logic [`KMUL_W-1:0]   x,
    output logic [`KMUL_W-1:0]   y,
    output logic                 start,                     // Access-phase pulse
    output logic                 clear_done,
    input  kmul_stat_t           stat,                      // Busy and done from the controller
    input  logic [2*`KMUL_W-1:0] result
);

    kmul_wdata_u wdata;                                     // PWDATA seen through both views
    kmul_stat_t  stat_rd;
    logic        access;                                    // Completing transfer
    logic        wr_opnd;
    logic        wr_ctrl;
    logic        mapped;
    logic        start_busy;                                // Rejected start
    logic        overrun_q;                                 // Sticky until clear_done
    logic [`KMUL_W-1:0] x_q;
    logic [`KMUL_W-1:0] y_q;

    assign wdata  = PWDATA;
    assign access = PSEL && PENABLE;                        // No wait states
    assign mapped = (PADDR == `KMUL_ADDR_OPND) || (PADDR == `KMUL_ADDR_CTRL)
                 || (PADDR == `KMUL_ADDR_STAT) || (PADDR == `KMUL_ADDR_RES);

    assign wr_opnd = access && PWRITE && (PADDR == `KMUL_ADDR_OPND);
    assign wr_ctrl = access && PWRITE && (PADDR == `KMUL_ADDR_CTRL);

    assign start_busy = wr_ctrl && wdata.ctrl.start && stat.busy;
    assign start      = wr_ctrl && wdata.ctrl.start && !stat.busy;
    assign clear_done = wr_ctrl && wdata.ctrl.clear_done;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            x_q       <= '0;
            y_q       <= '0;
            overrun_q <= 1'b0;
        end else begin
            if (wr_opnd) begin
                x_q <= wdata.opnd.x;                        // Safe while busy
                y_q <= wdata.opnd.y;
            end
            if (start_busy) begin
                overrun_q <= 1'b1;
            end else if (clear_done) begin
                overrun_q <= 1'b0;                          // Cleared along with done
            end
        end
    end

    assign x = x_q;
    assign y = y_q;

    always_comb begin
        stat_rd         = stat;
        stat_rd.overrun = overrun_q;                        // Merge the local flag
        case (PADDR)
            `KMUL_ADDR_OPND: PRDATA = {16'h0000, x_q, y_q};
            `KMUL_ADDR_STAT: PRDATA = {29'h0, stat_rd};     // Bit 0 busy, 1 done, 2 overrun
            `KMUL_ADDR_RES:  PRDATA = {16'h0000, result};
            default:         PRDATA = '0;                   // CTRL reads as zero
        endcase
    end

    assign PREADY  = 1'b1;
    assign PSLVERR = access && (!mapped || start_busy);

endmodule

/* verilog/kmul_ctrl.sv */
`include "kmul_defines.svh"

module kmul_ctrl import kmul_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       start,                               // One-cycle pulse, cycle 0
    input  logic       clear_done,                          // One-cycle pulse from the APB slave
    output kmul_ctrl_t ctrl,
    output kmul_stat_t stat
);

    logic [`KMUL_LATENCY-1:0] step_q;                       // One-hot, bit n is cycle n+1
    logic                     done_q;

    // Start enters bit 0 and walks up one bit per clock
    always_ff @(posedge CLK) begin
        if (RESET) begin
            step_q <= '0;
        end else begin
            step_q <= {step_q[`KMUL_LATENCY-2:0], start};
        end
    end

    // Done set on the combine step, dropped by clear or a fresh start
    always_ff @(posedge CLK) begin
        if (RESET) begin
            done_q <= 1'b0;
        end else if (step_q[6]) begin
            done_q <= 1'b1;                                 // Same edge as the result load
        end else if (start || clear_done) begin
            done_q <= 1'b0;
        end
    end

    // Strobe decode
    always_comb begin
        ctrl        = '0;
        ctrl.ld_xy  = step_q[0];                            // Cycle 1
        ctrl.ld_sum = step_q[1];                            // Cycle 2
        ctrl.ld_a   = step_q[2];                            // Cycle 3
        ctrl.ld_b   = step_q[3];                            // Cycle 4
        ctrl.ld_p   = step_q[4];                            // Cycle 5
        ctrl.ld_mid = step_q[5];                            // Cycle 6
        ctrl.ld_res = step_q[6];                            // Cycle 7
        // ROM address leads each capture by one cycle
        if (step_q[1]) begin
            ctrl.rom_sel = 2'd1;                            // Low nibbles
        end else if (step_q[2]) begin
            ctrl.rom_sel = 2'd2;                            // High nibbles
        end else if (step_q[3]) begin
            ctrl.rom_sel = 2'd3;                            // Nibble sums
        end
    end

    // Overrun lives in the APB slave
    assign stat.busy    = |step_q;
    assign stat.done    = done_q;
    assign stat.overrun = 1'b0;

endmodule

/* verilog/kmul_datapath.sv */
`include "kmul_defines.svh"

module kmul_datapath import kmul_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [`KMUL_W-1:0]    x,                        // Operand from the register file
    input  logic [`KMUL_W-1:0]    y,
    input  kmul_ctrl_t            ctrl,                     // Strobes from the controller
    output logic [2*`KMUL_W-1:0]  result
);

    localparam int H = `KMUL_W / 2;                         // Nibble width

    logic [`KMUL_W-1:0]      x_q;                           // Private operand copy
    logic [`KMUL_W-1:0]      y_q;
    logic [H:0]              d_q;                           // x high + x low
    logic [H:0]              e_q;                           // y high + y low
    logic [`KMUL_ROM_DW-1:0] a_q;                           // xl * yl
    logic [`KMUL_ROM_DW-1:0] b_q;                           // xh * yh
    logic [`KMUL_ROM_DW-1:0] p_q;                           // D * E
    logic [`KMUL_ROM_DW-1:0] mid_q;                         // xh*yl + xl*yh, never negative
    logic [2*`KMUL_W-1:0]    res_q;

    logic [`KMUL_ROM_AW-1:0] rom_addr;
    logic [`KMUL_ROM_DW-1:0] rom_data;                      // Valid the cycle after rom_addr
    logic [`KMUL_ROM_DW-1:0] mid_d;
    logic [2*`KMUL_W-1:0]    res_d;

    kmul_prod_rom u_rom (
        .CLK  (CLK),
        .addr (rom_addr),
        .data (rom_data)
    );

    // ROM address mux, nibbles zero-extended to the 5-bit factor width
    always_comb begin
        case (ctrl.rom_sel)
            2'd1:    rom_addr = {1'b0, x_q[H-1:0], 1'b0, y_q[H-1:0]};              // Low pair
            2'd2:    rom_addr = {1'b0, x_q[`KMUL_W-1:H], 1'b0, y_q[`KMUL_W-1:H]};  // High pair
            2'd3:    rom_addr = {d_q, e_q};                                        // Sums
            default: rom_addr = '0;                         // Idle
        endcase
    end

    // Karatsuba middle term
    assign mid_d = p_q - a_q - b_q;

    // B fits in 8 bits since both high nibbles are at most 15
    assign res_d = {b_q[`KMUL_W-1:0], `KMUL_W'(0)}
                 + {2'b00, mid_q, 4'h0}
                 + {6'h00, a_q};

    // Payload registers, only the strobes matter
    always_ff @(posedge CLK) begin
        if (ctrl.ld_xy) begin
            x_q <= x;                                       // Later OPND writes leave this alone
            y_q <= y;
        end
        if (ctrl.ld_sum) begin
            d_q <= {1'b0, x_q[`KMUL_W-1:H]} + {1'b0, x_q[H-1:0]};
            e_q <= {1'b0, y_q[`KMUL_W-1:H]} + {1'b0, y_q[H-1:0]};
        end
        if (ctrl.ld_a) begin
            a_q <= rom_data;
        end
        if (ctrl.ld_b) begin
            b_q <= rom_data;
        end
        if (ctrl.ld_p) begin
            p_q <= rom_data;
        end
        if (ctrl.ld_mid) begin
            mid_q <= mid_d;
        end
    end

    // Result is host visible, so it starts at zero
    always_ff @(posedge CLK) begin
        if (RESET) begin
            res_q <= '0;
        end else if (ctrl.ld_res) begin
            res_q <= res_d;                                 // B<<8 + mid<<4 + A
        end
    end

    assign result = res_q;

endmodule

/* verilog/kmul_defines.svh */
`ifndef KMUL_DEFINES_SVH
`define KMUL_DEFINES_SVH

// Operand width, datapath split assumes two 4-bit nibbles
`define KMUL_W          8

// Product table of two 5-bit factors
`define KMUL_ROM_AW     10                                  // Two 5-bit factors side by side
`define KMUL_ROM_DW     10                                  // 31 * 31 fits in 10 bits

// APB byte offsets
`define KMUL_ADDR_OPND  4'h0                                // x in 15:8, y in 7:0
`define KMUL_ADDR_CTRL  4'h4                                // Start and clear_done
`define KMUL_ADDR_STAT  4'h8                                // Overrun, done, busy
`define KMUL_ADDR_RES   4'hC                                // 16-bit product

// Clocks from the start write to done
`define KMUL_LATENCY    7

`endif

/* verilog/kmul_pkg.sv */
`include "kmul_defines.svh"

package kmul_pkg;

    // Datapath strobes, one field per load enable
    typedef struct packed {
        logic       ld_xy;                                  // Capture operands
        logic       ld_sum;                                 // Register nibble sums D and E
        logic [1:0] rom_sel;                                // 0 idle, 1 low, 2 high, 3 sums
        logic       ld_a;                                   // Low nibble product
        logic       ld_b;                                   // High nibble product
        logic       ld_p;                                   // Product of the sums
        logic       ld_mid;                                 // P - A - B
        logic       ld_res;                                 // Final combine
    } kmul_ctrl_t;

    // Status flags, busy lands in bit 0 of STAT
    typedef struct packed {
        logic overrun;                                      // Start seen while busy
        logic done;                                         // Result valid
        logic busy;                                         // Sequence running
    } kmul_stat_t;

    // Operand view of an APB write word
    typedef struct packed {
        logic [31-2*`KMUL_W:0] rsvd;                        // Ignored
        logic [`KMUL_W-1:0]    x;
        logic [`KMUL_W-1:0]    y;
    } kmul_opnd_view_t;

    // Control view of an APB write word
    typedef struct packed {
        logic [29:0] rsvd;                                  // Ignored
        logic        clear_done;
        logic        start;
    } kmul_ctrl_view_t;

    // PADDR picks which view is meaningful
    typedef union packed {
        kmul_opnd_view_t opnd;
        kmul_ctrl_view_t ctrl;
    } kmul_wdata_u;

endpackage

/* verilog/kmul_prod_rom.sv */
`include "kmul_defines.svh"

module kmul_prod_rom (
    input  logic                    CLK,
    input  logic [`KMUL_ROM_AW-1:0] addr,                   // {factor a, factor b}
    output logic [`KMUL_ROM_DW-1:0] data                    // a * b, one cycle later
);

    localparam int FW = `KMUL_ROM_AW / 2;                   // Bits per factor
    localparam int DEPTH = 1 << `KMUL_ROM_AW;

    logic [`KMUL_ROM_DW-1:0] rom_mem [DEPTH];               // Product table
    logic [`KMUL_ROM_DW-1:0] data_q;                        // Output register

    // Table built once, every factor pair of the address space
    initial begin
        for (int i = 0; i < (1 << FW); i++) begin
            for (int j = 0; j < (1 << FW); j++) begin
                rom_mem[(i << FW) | j] = `KMUL_ROM_DW'(i * j);  // Upper half times lower half
            end
        end
    end

    // Synchronous read like a block ROM
    always_ff @(posedge CLK) begin
        data_q <= rom_mem[addr];
    end

    assign data = data_q;

endmodule

/* verilog/kmul_top.sv */
`include "kmul_defines.svh"

module kmul_top import kmul_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [3:0]  PADDR,
    input  logic [31:0] PWDATA,
    output logic [31:0] PRDATA,
    output logic        PREADY,
    output logic        PSLVERR
);

    logic [`KMUL_W-1:0]   x;                                // Operand register contents
    logic [`KMUL_W-1:0]   y;
    logic                 start;
    logic                 clear_done;
    kmul_ctrl_t           ctrl;                             // Controller to datapath
    kmul_stat_t           stat;                             // Controller to APB slave
    logic [2*`KMUL_W-1:0] result;

    kmul_apb_regs u_apb (
        .CLK        (CLK),
        .RESET      (RESET),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .x          (x),
        .y          (y),
        .start      (start),
        .clear_done (clear_done),
        .stat       (stat),
        .result     (result)
    );

    kmul_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .start      (start),
        .clear_done (clear_done),
        .ctrl       (ctrl),
        .stat       (stat)
    );

    kmul_datapath u_dp (
        .CLK    (CLK),
        .RESET  (RESET),
        .x      (x),
        .y      (y),
        .ctrl   (ctrl),
        .result (result)
    );

endmodule
